// ==== logic/mul_ctrl_pkg.sv ====
package mul_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Arithmetic mode
    ////////////////////////////////////////////////////////////

    // Chosen per operand pair
    typedef enum logic {
        MODE_EXACT  = 1'b0,
        MODE_APPROX = 1'b1     // low field product left out
    } mul_mode_e;

    ////////////////////////////////////////////////////////////
    // Pipeline control
    ////////////////////////////////////////////////////////////

    // Rides beside the data from stage to stage
    typedef struct packed {
        logic      valid;
        mul_mode_e mode;
        // Set when the final product is negative
        logic      sign;
    } stage_ctrl_t;

endpackage

// ==== logic/mul_data_pkg.sv ====
package mul_data_pkg;

    ////////////////////////////////////////////////////////////
    // Field layout
    ////////////////////////////////////////////////////////////

    localparam int FIELD_CNT   = 3;
    localparam int FIELD_BUF_W = 3;                // widest field held
    localparam int PROD_W      = 2 * FIELD_BUF_W;
    localparam int ROW_W       = 8;

    // Width of field k, low field first
    function automatic int field_width(input int lo_w, input int k);
        int rest;
        rest = 7 - lo_w;
        case (k)
            0:       return lo_w;
            1:       return rest / 2;
            default: return rest - rest / 2;
        endcase
    endfunction

    // Bit position of field k inside the 7-bit magnitude
    function automatic int field_offset(input int lo_w, input int k);
        case (k)
            0:       return 0;
            1:       return lo_w;
            default: return lo_w + field_width(lo_w, 1);
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Operands
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       sgn;
        logic [6:0] low;
    } operand_fields_t;

    // One byte, seen as raw bits, signed value or sign plus low bits
    typedef union packed {
        logic [7:0]        raw;
        logic signed [7:0] sval;
        operand_fields_t   f;
    } operand_u;

    typedef struct packed {
        operand_u a;
        operand_u b;
    } operand_pair_t;

    // Magnitudes run 0 to 128, so bit 7 only ever marks 128
    typedef struct packed {
        logic [7:0] mag_a;
        logic [7:0] mag_b;
        logic       sign;
    } mag_pair_t;

    ////////////////////////////////////////////////////////////
    // Partial products and result
    ////////////////////////////////////////////////////////////

    typedef logic [PROD_W-1:0] field_prod_t;

    // prod[i][j] is field i of a times field j of b
    // Row bit 7 flags the 128 case, bits 6:0 hold the gated row
    typedef struct packed {
        field_prod_t [FIELD_CNT-1:0][FIELD_CNT-1:0] prod;
        logic [ROW_W-1:0]                           row_a7;
        logic [ROW_W-1:0]                           row_b7;
    } field_products_t;

    typedef logic [15:0] result_t;

endpackage

// ==== logic/sign_magnitude.sv ====
module sign_magnitude (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  mul_data_pkg::operand_pair_t operands,
    input  mul_ctrl_pkg::mul_mode_e     mode,
    output mul_data_pkg::mag_pair_t     mags,
    output mul_ctrl_pkg::stage_ctrl_t   ctrl
);

    import mul_data_pkg::*;

    ////////////////////////////////////////////////////////////
    // Magnitude and sign
    ////////////////////////////////////////////////////////////

    // Negative operands are negated as signed values
    // -128 wraps to 8'h80, which reads as 128 unsigned
    function automatic logic [7:0] magnitude(input operand_u op);
        return op.f.sgn ? 8'(-op.sval) : op.raw;
    endfunction

    mag_pair_t mags_d;

    always_comb begin
        mags_d.mag_a = magnitude(operands.a);
        mags_d.mag_b = magnitude(operands.b);
        mags_d.sign  = operands.a.f.sgn ^ operands.b.f.sgn;
    end

    ////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        mags      <= mags_d;
        ctrl.mode <= mode;
        ctrl.sign <= mags_d.sign;
        if (rst) begin
            ctrl.valid <= 1'b0;
        end else begin
            ctrl.valid <= in_valid;
        end
    end

    // Later stages only cover 0..128 with the bit-7 rows
    mag_in_range: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.valid |-> (mags.mag_a <= 8'd128) && (mags.mag_b <= 8'd128)
    ) else $error("magnitude out of range a=%h b=%h", mags.mag_a, mags.mag_b);

endmodule

// ==== logic/field_product_array.sv ====
module field_product_array #(
    parameter int FIELD_LO_W = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  mul_data_pkg::mag_pair_t       mags,
    input  mul_ctrl_pkg::stage_ctrl_t     ctrl_in,
    output mul_data_pkg::field_products_t fields,
    output mul_ctrl_pkg::stage_ctrl_t     ctrl_out
);

    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;

    // All three fields must fit the 3-bit field buffers
    if (FIELD_LO_W < 1 || FIELD_LO_W > FIELD_BUF_W) begin : g_bad_width
        $error("FIELD_LO_W must lie in 1..%0d", FIELD_BUF_W);
    end

    logic [FIELD_CNT-1:0][FIELD_BUF_W-1:0]      fa;
    logic [FIELD_CNT-1:0][FIELD_BUF_W-1:0]      fb;
    field_prod_t [FIELD_CNT-1:0][FIELD_CNT-1:0] prod_d;

    ////////////////////////////////////////////////////////////
    // Field split of bits 6:0
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < FIELD_CNT; k++) begin : g_split
        localparam int         OFF  = field_offset(FIELD_LO_W, k);
        localparam int         W    = field_width(FIELD_LO_W, k);
        localparam logic [6:0] MASK = 7'((1 << W) - 1);

        assign fa[k] = FIELD_BUF_W'((mags.mag_a[6:0] >> OFF) & MASK);
        assign fb[k] = FIELD_BUF_W'((mags.mag_b[6:0] >> OFF) & MASK);
    end

    ////////////////////////////////////////////////////////////
    // Nine cross products
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < FIELD_CNT; i++) begin : g_row
        for (genvar j = 0; j < FIELD_CNT; j++) begin : g_col
            field_prod_t pp;

            // AND array with one shifted row per bit of the b field
            always_comb begin
                pp = '0;
                for (int k = 0; k < FIELD_BUF_W; k++) begin
                    pp += field_prod_t'(fa[i] & {FIELD_BUF_W{fb[j][k]}}) << k;
                end
            end

            if (i == 0 && j == 0) begin : g_low
                // Approximate mode drops the low-by-low term
                assign prod_d[i][j] = (ctrl_in.mode == MODE_APPROX) ? '0 : pp;
            end else begin : g_keep
                assign prod_d[i][j] = pp;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        fields.prod <= prod_d;
        // Bit-7 rows hold the other low seven bits gated by bit 7
        fields.row_a7 <= {mags.mag_a[7], mags.mag_b[6:0] & {7{mags.mag_a[7]}}};
        fields.row_b7 <= {mags.mag_b[7], mags.mag_a[6:0] & {7{mags.mag_b[7]}}};
        ctrl_out.mode <= ctrl_in.mode;
        ctrl_out.sign <= ctrl_in.sign;
        if (rst) begin
            ctrl_out.valid <= 1'b0;
        end else begin
            ctrl_out.valid <= ctrl_in.valid;
        end
    end

endmodule

// ==== logic/product_accumulator.sv ====
module product_accumulator #(
    parameter int FIELD_LO_W = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  mul_data_pkg::field_products_t fields,
    input  mul_ctrl_pkg::stage_ctrl_t     ctrl_in,
    output mul_data_pkg::result_t         product,
    output logic                          out_valid
);

    import mul_data_pkg::*;

    localparam int NUM_TERMS = FIELD_CNT * FIELD_CNT;

    result_t [NUM_TERMS-1:0] terms;
    result_t                 row_sum;
    result_t                 sum;

    ////////////////////////////////////////////////////////////
    // Alignment
    ////////////////////////////////////////////////////////////

    // Each product sits at the sum of its two field offsets
    for (genvar i = 0; i < FIELD_CNT; i++) begin : g_row
        for (genvar j = 0; j < FIELD_CNT; j++) begin : g_col
            localparam int SHIFT = field_offset(FIELD_LO_W, i)
                                 + field_offset(FIELD_LO_W, j);

            assign terms[i*FIELD_CNT + j] = result_t'(fields.prod[i][j]) << SHIFT;
        end
    end

    // Bit-7 rows both weigh 2^7
    always_comb begin
        row_sum = (result_t'(fields.row_a7[6:0]) << 7)
                + (result_t'(fields.row_b7[6:0]) << 7);
        // 128 times 128
        if (fields.row_a7[7] && fields.row_b7[7]) begin
            row_sum += result_t'(1) << 14;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sum of magnitudes
    ////////////////////////////////////////////////////////////

    always_comb begin
        sum = row_sum;
        for (int t = 0; t < NUM_TERMS; t++) begin
            sum += terms[t];
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage register, sign applied last
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        product <= ctrl_in.sign ? -sum : sum;
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl_in.valid;
        end
    end

    // Valid chain must be clean once reset has flushed the pipe
    valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(out_valid)
    ) else $error("out_valid unknown after reset");

endmodule

// ==== logic/mul_top.sv ====
module mul_top #(
    parameter int FIELD_LO_W = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  mul_data_pkg::operand_pair_t operands,
    input  mul_ctrl_pkg::mul_mode_e     mode,
    output mul_data_pkg::result_t       product,
    output logic                        out_valid
);

    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;

    ////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////

    mag_pair_t       mags;
    stage_ctrl_t     ctrl_s1;
    field_products_t fields;
    stage_ctrl_t     ctrl_s2;

    ////////////////////////////////////////////////////////////
    // Three-stage pipeline, one cycle each
    ////////////////////////////////////////////////////////////

    // Stage 1, operands to magnitudes
    sign_magnitude u_sign_magnitude (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .operands (operands),
        .mode     (mode),
        .mags     (mags),
        .ctrl     (ctrl_s1)
    );

    // Stage 2, field products and bit-7 rows
    field_product_array #(
        .FIELD_LO_W (FIELD_LO_W)
    ) u_field_product_array (
        .clk      (clk),
        .rst      (rst),
        .mags     (mags),
        .ctrl_in  (ctrl_s1),
        .fields   (fields),
        .ctrl_out (ctrl_s2)
    );

    // Stage 3, weighted sum and sign
    product_accumulator #(
        .FIELD_LO_W (FIELD_LO_W)
    ) u_product_accumulator (
        .clk       (clk),
        .rst       (rst),
        .fields    (fields),
        .ctrl_in   (ctrl_s2),
        .product   (product),
        .out_valid (out_valid)
    );

endmodule

// ==== verif/mul_checker.sv ====
module mul_checker #(
    parameter int FIELD_LO_W = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  mul_data_pkg::operand_pair_t operands,
    input  mul_ctrl_pkg::mul_mode_e     mode,
    input  logic                        golden_valid,
    input  mul_data_pkg::result_t       golden_product,
    input  mul_data_pkg::result_t       product,
    input  logic                        out_valid,
    output int                          pending,
    output int                          checked,
    output int                          value_errors,
    output int                          other_errors
);

    timeunit 1ns;
    timeprecision 1ps;

    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;

    localparam int LATENCY = 3;

    // One accepted input waiting for its result
    typedef struct packed {
        int            issue_cycle;
        operand_pair_t ops;
        mul_mode_e     op_mode;
        result_t       expected;
    } pending_t;

    pending_t q[$];
    int       cycle = 0;
    int       n_pending = 0;
    int       n_checked = 0;
    int       n_value_err = 0;
    int       n_other_err = 0;
    logic     reset_seen = 1'b0;

    assign pending      = n_pending;
    assign checked      = n_checked;
    assign value_errors = n_value_err;
    assign other_errors = n_other_err;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Signed product; approx drops low field times low field before the sign
    function automatic result_t predict_product(input operand_pair_t ops, input mul_mode_e m);
        int   sa;
        int   sb;
        int   ma;
        int   mb;
        int   mag;
        int   low_mask;
        logic neg;
        sa  = ops.a.sval;
        sb  = ops.b.sval;
        ma  = (sa < 0) ? -sa : sa;
        mb  = (sb < 0) ? -sb : sb;
        neg = (sa < 0) != (sb < 0);
        mag = ma * mb;
        if (m == MODE_APPROX) begin
            low_mask = (1 << FIELD_LO_W) - 1;
            mag      = mag - (ma & low_mask) * (mb & low_mask);
        end
        return result_t'(neg ? -mag : mag);
    endfunction

    ////////////////////////////////////////////////////////////
    // Input capture and output compare
    ////////////////////////////////////////////////////////////

    task automatic accept_input();
        pending_t entry;
        entry.issue_cycle = cycle;
        entry.ops         = operands;
        entry.op_mode     = mode;
        entry.expected    = golden_valid ? golden_product : predict_product(operands, mode);
        q.push_back(entry);
    endtask

    task automatic check_output();
        pending_t head;
        if (out_valid === 1'b1) begin
            if (q.size() == 0) begin
                $display("out_valid went high at cycle %0d with no input waiting", cycle);
                n_other_err++;
            end else begin
                head = q.pop_front();
                n_checked++;
                if (cycle != head.issue_cycle + LATENCY) begin
                    $display("Result for the input of cycle %0d came at cycle %0d, not %0d",
                             head.issue_cycle, cycle, head.issue_cycle + LATENCY);
                    n_other_err++;
                end
                if (product !== head.expected) begin
                    $display("ERROR product=%h expected=%h (a=%h b=%h %s)", product,
                             head.expected, head.ops.a.raw, head.ops.b.raw,
                             (head.op_mode == MODE_APPROX) ? "approx" : "exact");
                    n_value_err++;
                end
            end
        end else if (out_valid !== 1'b0) begin
            $display("out_valid is unknown at cycle %0d", cycle);
            n_other_err++;
        end else if (q.size() != 0 && cycle >= q[0].issue_cycle + LATENCY) begin
            head = q.pop_front();
            $display("No result for the input of cycle %0d, out_valid stayed low",
                     head.issue_cycle);
            n_other_err++;
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (rst) begin
            // Valid bits are cleared by the first reset edge
            if (reset_seen && out_valid !== 1'b0) begin
                $display("ERROR out_valid=%h expected=0 during reset", out_valid);
                n_value_err++;
            end
            reset_seen = 1'b1;
            q.delete();
        end else begin
            check_output();
            if (in_valid === 1'b1) begin
                accept_input();
            end else if (in_valid !== 1'b0) begin
                $display("in_valid is unknown at cycle %0d", cycle);
                n_other_err++;
            end
        end
        n_pending = q.size();
    end

endmodule

// ==== verif/tb_mul_top.sv ====
module tb_mul_top;

    timeunit 1ns;
    timeprecision 1ps;

    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;

    localparam int FIELD_LO_W   = 3;
    localparam int DRAIN_CYCLES = 100;
    localparam int MAX_LINES    = 1000;

    logic          clk;
    logic          rst;
    logic          in_valid;
    operand_pair_t operands;
    mul_mode_e     mode;
    result_t       product;
    logic          out_valid;

    // Expected value from the golden file, beside its vector
    logic          golden_valid;
    result_t       golden_product;

    int            pending;
    int            checked;
    int            value_errors;
    int            other_errors;
    int            tb_errors;
    logic [31:0]   lfsr;

    mul_top #(
        .FIELD_LO_W (FIELD_LO_W)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .operands  (operands),
        .mode      (mode),
        .product   (product),
        .out_valid (out_valid)
    );

    mul_checker #(
        .FIELD_LO_W (FIELD_LO_W)
    ) u_checker (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .operands       (operands),
        .mode           (mode),
        .golden_valid   (golden_valid),
        .golden_product (golden_product),
        .product        (product),
        .out_valid      (out_valid),
        .pending        (pending),
        .checked        (checked),
        .value_errors   (value_errors),
        .other_errors   (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic drive_vector(input logic [7:0] a, input logic [7:0] b, input mul_mode_e m,
                                input logic from_golden, input result_t expected);
        @(negedge clk);
        in_valid       = 1'b1;
        operands.a.raw = a;
        operands.b.raw = b;
        mode           = m;
        golden_valid   = from_golden;
        golden_product = expected;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid     = 1'b0;
            golden_valid = 1'b0;
        end
    endtask

    // Golden vectors go in back to back, modes mixed line by line
    task automatic replay_golden();
        int          fd;
        int          n;
        int          line_no;
        int          vectors;
        string       line;
        logic [31:0] ga;
        logic [31:0] gb;
        logic [31:0] gm;
        logic [31:0] gexp;
        fd = $fopen("verif/mul_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/mul_golden.txt");
            tb_errors++;
            return;
        end
        line_no = 0;
        vectors = 0;
        while (!$feof(fd) && line_no < MAX_LINES) begin
            n = $fgets(line, fd);
            line_no++;
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h", ga, gb, gm, gexp);
                if (n == 4) begin
                    drive_vector(ga[7:0], gb[7:0], gm[0] ? MODE_APPROX : MODE_EXACT,
                                 1'b1, gexp[15:0]);
                    vectors++;
                end else if (n > 0) begin
                    $display("Golden file line %0d could not be parsed", line_no);
                    tb_errors++;
                end
            end
        end
        $fclose(fd);
        if (vectors == 0) begin
            $display("The golden file held no vectors");
            tb_errors++;
        end
    endtask

    // Gap of 0 to 3 idle cycles after each strobe
    task automatic random_phase(input int count, input logic approx_only);
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] m;
        logic [7:0] g;
        mul_mode_e  vm;
        for (int i = 0; i < count; i++) begin
            random_bits(8, a);
            random_bits(8, b);
            random_bits(1, m);
            random_bits(2, g);
            vm = (approx_only || m[0]) ? MODE_APPROX : MODE_EXACT;
            drive_vector(a, b, vm, 1'b0, '0);
            idle_cycles(int'(g[1:0]));
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        idle_cycles(1);
        waited = 0;
        while (pending != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("Timeout, %0d results still missing after %0d cycles",
                     pending, DRAIN_CYCLES);
            tb_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst            = 1'b1;
        in_valid       = 1'b0;
        operands       = '0;
        mode           = MODE_EXACT;
        golden_valid   = 1'b0;
        golden_product = '0;
        tb_errors      = 0;
        lfsr           = 32'h4487;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Quiet pipe before the first strobe
        idle_cycles(6);
        replay_golden();
        idle_cycles(5);
        random_phase(500, 1'b1);
        random_phase(300, 1'b0);
        drain_pipeline();
        // Trailing idle cycles catch a stray out_valid
        idle_cycles(4);
        if (checked == 0) begin
            $display("No results were checked");
            tb_errors++;
        end
        $display("Checked %0d results: %0d value errors, %0d timing errors, %0d testbench errors",
                 checked, value_errors, other_errors, tb_errors);
        if (value_errors + other_errors + tb_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== fieldmul.f ====
logic/mul_ctrl_pkg.sv
logic/mul_data_pkg.sv
logic/sign_magnitude.sv
logic/field_product_array.sv
logic/product_accumulator.sv
logic/mul_top.sv
verif/mul_checker.sv
verif/tb_mul_top.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_mul_top

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

# Rebuilt only when the file list or a source listed in it changes
$(SIM): fieldmul.f $(shell grep -v '^+' fieldmul.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_mul_top -f fieldmul.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== verif/mul_golden.txt ====
# a b mode expected, all hex
# mode 0 exact, mode 1 leaves out the low field product
00 00 0 0000
7f 7f 0 3f01
81 81 0 3f01
7f 81 0 c0ff
80 80 0 4000
80 7f 0 c080
80 01 0 ff80
ff ff 0 0001
ff 01 0 ffff
00 80 0 0000
05 07 0 0023
80 81 0 3f80
12 f3 0 ff16
7f 7f 1 3ed0
81 7f 1 c130
80 80 1 4000
07 07 1 0000
05 f9 1 0000
0b 0d 1 0080
f5 0d 1 ff80
80 ff 1 0080
64 c8 1 ea20
3f 2b 1 0a80
3f 2b 0 0a95
